/* logic/pcpu_pkg.sv */
`default_nettype none

package pcpu_pkg;

	localparam int WORD_WIDTH    = 16;
	localparam int ADDR_WIDTH    = 8;
	localparam int MEM_DEPTH     = 256;
	localparam int REG_COUNT     = 8;
	localparam int REG_IDX_WIDTH = 3;

	// instruction word layout
	localparam int OP_MSB     = 15;
	localparam int OP_LSB     = 11;
	localparam int R1_MSB     = 10;
	localparam int R2_MSB     = 6;
	localparam int R3_MSB     = 2;
	localparam int IMM4_WIDTH = 4;
	localparam int IMM8_WIDTH = 8;

	typedef logic [WORD_WIDTH-1:0]    word_t;
	typedef logic [ADDR_WIDTH-1:0]    addr_t;
	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

	typedef enum logic [OP_MSB-OP_LSB:0] {
		OP_NOP   = 5'b00000,
		OP_HALT  = 5'b00001,
		OP_LOAD  = 5'b00010,
		OP_STORE = 5'b00011,
		OP_SLL   = 5'b00100,
		OP_SLA   = 5'b00101,
		OP_SRL   = 5'b00110,
		OP_SRA   = 5'b00111,
		OP_ADD   = 5'b01000,
		OP_ADDI  = 5'b01001,
		OP_SUB   = 5'b01011,
		OP_AND   = 5'b01101,
		OP_XOR   = 5'b01110,
		OP_OR    = 5'b01111,
		OP_LDIH  = 5'b10000,
		OP_SUBI  = 5'b10011
	} opcode_e;

	typedef enum logic {
		RUN_IDLE = 1'b0,
		RUN_EXEC = 1'b1
	} run_state_e;

	// all-zero word decodes as NOP
	localparam word_t NOP_WORD = '0;

	function automatic opcode_e op_of(input word_t ir);
		return opcode_e'(ir[OP_MSB:OP_LSB]);
	endfunction

	function automatic reg_idx_t r1_of(input word_t ir);
		return ir[R1_MSB -: REG_IDX_WIDTH];
	endfunction

	function automatic reg_idx_t r2_of(input word_t ir);
		return ir[R2_MSB -: REG_IDX_WIDTH];
	endfunction

	function automatic reg_idx_t r3_of(input word_t ir);
		return ir[R3_MSB -: REG_IDX_WIDTH];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// classification

	function automatic logic writes_register(input opcode_e op);
		return op inside {OP_LOAD, OP_LDIH, OP_ADD, OP_ADDI, OP_SUB, OP_SUBI,
			OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SLA, OP_SRA};
	endfunction

	function automatic logic reads_r3(input opcode_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
	endfunction

	function automatic logic reads_r2(input opcode_e op);
		return op inside {OP_LOAD, OP_STORE, OP_SLL, OP_SRL, OP_SLA, OP_SRA,
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
	endfunction

	// r1 as a source, store data or immediate base
	function automatic logic reads_r1(input opcode_e op);
		return op inside {OP_ADDI, OP_SUBI, OP_LDIH, OP_STORE};
	endfunction

endpackage

`default_nettype wire

/* logic/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import pcpu_pkg::*;
(
	input  wire           clock,
	input  wire           reset,
	input  wire           i_start,
	input  wire           i_enable,
	input  wire           i_imem_we,
	input  wire addr_t    i_imem_addr,
	input  wire word_t    i_imem_data,
	input  wire reg_idx_t i_id_load_dest,
	input  wire           i_id_is_load,
	input  wire reg_idx_t i_ex_load_dest,
	input  wire           i_ex_is_load,
	input  wire           i_halt_seen,
	output logic          o_advance,
	output logic          o_running,
	output word_t         o_id_ir
);

	run_state_e state;
	addr_t      pc;
	logic       draining;
	word_t      imem [MEM_DEPTH];
	word_t      fetch_word;
	logic       load_use;

	function automatic logic reads_reg(input word_t ir, input reg_idx_t idx);
		opcode_e op;
		op = op_of(ir);
		return (reads_r1(op) && r1_of(ir) == idx)
			|| (reads_r2(op) && r2_of(ir) == idx)
			|| (reads_r3(op) && r3_of(ir) == idx);
	endfunction

	assign o_running = (state == RUN_EXEC);
	assign o_advance = o_running && i_enable;

	// program image, written from outside while idle
	always_ff @(posedge clock)
	begin
		if (i_imem_we)
			imem[i_imem_addr] <= i_imem_data;
	end

	assign fetch_word = imem[pc];

	// loaded value not ready until the load reaches memory
	assign load_use = (i_id_is_load && reads_reg(fetch_word, i_id_load_dest))
		|| (i_ex_is_load && reads_reg(fetch_word, i_ex_load_dest));

	////////////////////////////////////////////////////////////////////////////
	// run control

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			state <= RUN_IDLE;
		else
		begin
			case (state)
				RUN_IDLE:
					if (i_start && i_enable)
						state <= RUN_EXEC;
				RUN_EXEC:
					if (i_enable && i_halt_seen)
						state <= RUN_IDLE;
				default:
					state <= RUN_IDLE;
			endcase
		end
	end

	// pc and the fetch register
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			pc       <= '0;
			draining <= 1'b0;
			o_id_ir  <= NOP_WORD;
		end
		else if (state == RUN_IDLE)
		begin
			if (i_start && i_enable)
			begin
				pc       <= '0;
				draining <= 1'b0;
			end
		end
		else if (o_advance)
		begin
			if (draining || load_use)
				o_id_ir <= NOP_WORD;
			else
			begin
				o_id_ir <= fetch_word;
				pc      <= pc + addr_t'(1);
				// nothing past HALT enters the pipeline
				if (op_of(fetch_word) == OP_HALT)
					draining <= 1'b1;
			end
		end
	end

	a_start_only: assert property (@(posedge clock) disable iff (!reset)
		$rose(o_running) |-> $past(i_start));

	a_pause_holds_pc: assert property (@(posedge clock) disable iff (!reset)
		!i_enable |=> $stable(pc));

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import pcpu_pkg::*;
(
	input  wire           clock,
	input  wire           reset,
	input  wire           i_advance,
	input  wire word_t    i_id_ir,
	input  wire word_t    i_ex_ir,
	input  wire word_t    i_alu_result,
	input  wire word_t    i_mem_ir,
	input  wire word_t    i_reg_c,
	input  wire           i_wb_en,
	input  wire reg_idx_t i_wb_idx,
	input  wire word_t    i_wb_data,
	output logic          o_id_is_load,
	output reg_idx_t      o_id_load_dest,
	output word_t         o_ex_ir,
	output word_t         o_reg_a,
	output word_t         o_reg_b,
	output word_t         o_store_data
);

	word_t    regs [REG_COUNT];
	opcode_e  id_op;
	reg_idx_t a_idx;
	word_t    a_value;
	word_t    b_value;
	word_t    store_value;

	// newest writer wins, execute then memory then writeback
	function automatic word_t forward(input reg_idx_t idx);
		if (writes_register(op_of(i_ex_ir)) && r1_of(i_ex_ir) == idx)
			return i_alu_result;
		else if (writes_register(op_of(i_mem_ir)) && r1_of(i_mem_ir) == idx)
			return i_reg_c;
		else if (i_wb_en && i_wb_idx == idx)
			return i_wb_data;
		else
			return regs[idx];
	endfunction

	assign id_op          = op_of(i_id_ir);
	assign o_id_is_load   = (id_op == OP_LOAD);
	assign o_id_load_dest = r1_of(i_id_ir);

	// immediate forms use r1 as base, everything else r2
	assign a_idx = (reads_r1(id_op) && !reads_r2(id_op)) ? r1_of(i_id_ir) : r2_of(i_id_ir);

	always_comb
	begin
		a_value     = forward(a_idx);
		store_value = forward(r1_of(i_id_ir));
		if (reads_r3(id_op))
			b_value = forward(r3_of(i_id_ir));
		else
			b_value = word_t'(i_id_ir[IMM4_WIDTH-1:0]);
	end

	////////////////////////////////////////////////////////////////////////////
	// register file

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
		begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (i_wb_en)
			regs[i_wb_idx] <= i_wb_data;
	end

	// decode to execute
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			o_ex_ir <= NOP_WORD;
		else if (i_advance)
			o_ex_ir <= i_id_ir;
	end

	always_ff @(posedge clock)
	begin
		if (i_advance)
		begin
			o_reg_a      <= a_value;
			o_reg_b      <= b_value;
			o_store_data <= store_value;
		end
	end

	// writeback must stay in step with the rest of the pipeline
	a_wb_on_advance: assert property (@(posedge clock) disable iff (!reset)
		i_wb_en |-> i_advance);

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import pcpu_pkg::*;
(
	input  wire        clock,
	input  wire        reset,
	input  wire        i_advance,
	input  wire word_t i_ex_ir,
	input  wire word_t i_reg_a,
	input  wire word_t i_reg_b,
	input  wire word_t i_store_data,
	output word_t      o_alu_result,
	output logic       o_ex_is_load,
	output reg_idx_t   o_ex_load_dest,
	output word_t      o_mem_ir,
	output word_t      o_reg_c,
	output logic       o_store_valid,
	output addr_t      o_store_addr,
	output word_t      o_store_data
);

	opcode_e               ex_op;
	word_t                 imm8;
	logic [IMM4_WIDTH-1:0] shamt;

	assign ex_op = op_of(i_ex_ir);
	assign imm8  = word_t'(i_ex_ir[IMM8_WIDTH-1:0]);

	// shift count rides in operand B as the 4-bit immediate
	assign shamt = i_reg_b[IMM4_WIDTH-1:0];

	////////////////////////////////////////////////////////////////////////////
	// ALU and shifter

	always_comb
	begin
		case (ex_op)
			// base plus 4-bit offset
			OP_LOAD,
			OP_STORE:
				o_alu_result = i_reg_a + i_reg_b;
			OP_LDIH:
				o_alu_result = i_reg_a + (imm8 << IMM8_WIDTH);
			OP_ADD:
				o_alu_result = i_reg_a + i_reg_b;
			OP_ADDI:
				o_alu_result = i_reg_a + imm8;
			OP_SUB:
				o_alu_result = i_reg_a - i_reg_b;
			OP_SUBI:
				o_alu_result = i_reg_a - imm8;
			OP_AND:
				o_alu_result = i_reg_a & i_reg_b;
			OP_OR:
				o_alu_result = i_reg_a | i_reg_b;
			OP_XOR:
				o_alu_result = i_reg_a ^ i_reg_b;
			OP_SLL,
			OP_SLA:
				o_alu_result = i_reg_a << shamt;
			OP_SRL:
				o_alu_result = i_reg_a >> shamt;
			OP_SRA:
				o_alu_result = word_t'($signed(i_reg_a) >>> shamt);
			default:
				o_alu_result = '0;
		endcase
	end

	// pending load destination for the stall check
	assign o_ex_is_load   = (ex_op == OP_LOAD);
	assign o_ex_load_dest = r1_of(i_ex_ir);

	// execute to memory
	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			o_mem_ir <= NOP_WORD;
		else if (i_advance)
			o_mem_ir <= i_ex_ir;
	end

	always_ff @(posedge clock)
	begin
		if (i_advance)
		begin
			o_reg_c      <= o_alu_result;
			o_store_data <= i_store_data;
		end
	end

	// one strobe per store, only on a cycle the pipeline moves
	assign o_store_valid = i_advance && (op_of(o_mem_ir) == OP_STORE);
	assign o_store_addr  = o_reg_c[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage import pcpu_pkg::*;
(
	input  wire        clock,
	input  wire        reset,
	input  wire        i_advance,
	input  wire word_t i_mem_ir,
	input  wire word_t i_reg_c,
	input  wire        i_store_valid,
	input  wire addr_t i_store_addr,
	input  wire word_t i_store_data,
	input  wire        i_dmem_we,
	input  wire addr_t i_dmem_addr,
	input  wire word_t i_dmem_data,
	output logic       o_wb_en,
	output reg_idx_t   o_wb_idx,
	output word_t      o_wb_data,
	output logic       o_halt_seen
);

	word_t dmem [MEM_DEPTH];
	word_t wb_ir;
	addr_t mem_addr;
	word_t load_word;

	// data memory, stores from the core or preload from outside
	always_ff @(posedge clock)
	begin
		if (i_store_valid)
			dmem[i_store_addr] <= i_store_data;
		else if (i_dmem_we)
			dmem[i_dmem_addr] <= i_dmem_data;
	end

	assign mem_addr  = i_reg_c[ADDR_WIDTH-1:0];
	assign load_word = dmem[mem_addr];

	////////////////////////////////////////////////////////////////////////////
	// writeback register

	always_ff @(posedge clock or negedge reset)
	begin
		if (!reset)
			wb_ir <= NOP_WORD;
		else if (i_advance)
			wb_ir <= i_mem_ir;
	end

	always_ff @(posedge clock)
	begin
		if (i_advance)
			o_wb_data <= (op_of(i_mem_ir) == OP_LOAD) ? load_word : i_reg_c;
	end

	assign o_wb_idx    = r1_of(wb_ir);
	assign o_wb_en     = i_advance && writes_register(op_of(wb_ir));
	assign o_halt_seen = (op_of(wb_ir) == OP_HALT);

	// preload port is only for an idle core
	a_no_load_during_store: assert property (@(posedge clock) disable iff (!reset)
		!(i_store_valid && i_dmem_we));

endmodule

`default_nettype wire

/* logic/pcpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pcpu_top import pcpu_pkg::*;
(
	input  wire        clock,
	input  wire        reset,
	input  wire        i_imem_we,
	input  wire addr_t i_imem_addr,
	input  wire word_t i_imem_data,
	input  wire        i_dmem_we,
	input  wire addr_t i_dmem_addr,
	input  wire word_t i_dmem_data,
	input  wire        i_start,
	input  wire        i_enable,
	output logic       o_running,
	output logic       o_store_valid,
	output addr_t      o_store_addr,
	output word_t      o_store_data
);

	logic     advance;
	word_t    id_ir;
	logic     id_is_load;
	reg_idx_t id_load_dest;
	word_t    ex_ir;
	word_t    reg_a;
	word_t    reg_b;
	word_t    ex_store_data;
	word_t    alu_result;
	logic     ex_is_load;
	reg_idx_t ex_load_dest;
	word_t    mem_ir;
	word_t    reg_c;
	logic     wb_en;
	reg_idx_t wb_idx;
	word_t    wb_data;
	logic     halt_seen;

	fetch_stage u_fetch (
		.clock          (clock),
		.reset          (reset),
		.i_start        (i_start),
		.i_enable       (i_enable),
		.i_imem_we      (i_imem_we),
		.i_imem_addr    (i_imem_addr),
		.i_imem_data    (i_imem_data),
		.i_id_load_dest (id_load_dest),
		.i_id_is_load   (id_is_load),
		.i_ex_load_dest (ex_load_dest),
		.i_ex_is_load   (ex_is_load),
		.i_halt_seen    (halt_seen),
		.o_advance      (advance),
		.o_running      (o_running),
		.o_id_ir        (id_ir)
	);

	decode_stage u_decode (
		.clock          (clock),
		.reset          (reset),
		.i_advance      (advance),
		.i_id_ir        (id_ir),
		.i_ex_ir        (ex_ir),
		.i_alu_result   (alu_result),
		.i_mem_ir       (mem_ir),
		.i_reg_c        (reg_c),
		.i_wb_en        (wb_en),
		.i_wb_idx       (wb_idx),
		.i_wb_data      (wb_data),
		.o_id_is_load   (id_is_load),
		.o_id_load_dest (id_load_dest),
		.o_ex_ir        (ex_ir),
		.o_reg_a        (reg_a),
		.o_reg_b        (reg_b),
		.o_store_data   (ex_store_data)
	);

	execute_stage u_execute (
		.clock          (clock),
		.reset          (reset),
		.i_advance      (advance),
		.i_ex_ir        (ex_ir),
		.i_reg_a        (reg_a),
		.i_reg_b        (reg_b),
		.i_store_data   (ex_store_data),
		.o_alu_result   (alu_result),
		.o_ex_is_load   (ex_is_load),
		.o_ex_load_dest (ex_load_dest),
		.o_mem_ir       (mem_ir),
		.o_reg_c        (reg_c),
		.o_store_valid  (o_store_valid),
		.o_store_addr   (o_store_addr),
		.o_store_data   (o_store_data)
	);

	memory_stage u_memory (
		.clock         (clock),
		.reset         (reset),
		.i_advance     (advance),
		.i_mem_ir      (mem_ir),
		.i_reg_c       (reg_c),
		.i_store_valid (o_store_valid),
		.i_store_addr  (o_store_addr),
		.i_store_data  (o_store_data),
		.i_dmem_we     (i_dmem_we),
		.i_dmem_addr   (i_dmem_addr),
		.i_dmem_data   (i_dmem_data),
		.o_wb_en       (wb_en),
		.o_wb_idx      (wb_idx),
		.o_wb_data     (wb_data),
		.o_halt_seen   (halt_seen)
	);

endmodule

`default_nettype wire

/* verification/pcpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pcpu_tb import pcpu_pkg::*;
();

	localparam int PROG_COUNT  = 4;
	localparam int PROG_LEN    = 24;
	localparam int DATA_COUNT  = 8;
	localparam int RUN_TIMEOUT = 400;

	logic  clock;
	logic  reset;
	logic  i_imem_we;
	addr_t i_imem_addr;
	word_t i_imem_data;
	logic  i_dmem_we;
	addr_t i_dmem_addr;
	word_t i_dmem_data;
	logic  i_start;
	logic  i_enable;
	logic  o_running;
	logic  o_store_valid;
	addr_t o_store_addr;
	word_t o_store_data;

	// program table, one row per program
	word_t prog_words [PROG_COUNT][PROG_LEN];
	int    prog_len   [PROG_COUNT];
	word_t data_words [PROG_COUNT][DATA_COUNT];
	int    pause_at   [PROG_COUNT];
	int    pause_len  [PROG_COUNT];

	// reference model state, registers persist across programs
	word_t model_regs [REG_COUNT];
	word_t model_dmem [MEM_DEPTH];
	addr_t exp_addr [$];
	word_t exp_data [$];
	addr_t got_addr [$];
	word_t got_data [$];

	integer seed;
	int     error_count;
	int     check_count;
	logic   timed_out;

	pcpu_top i_dut (
		.clock         (clock),
		.reset         (reset),
		.i_imem_we     (i_imem_we),
		.i_imem_addr   (i_imem_addr),
		.i_imem_data   (i_imem_data),
		.i_dmem_we     (i_dmem_we),
		.i_dmem_addr   (i_dmem_addr),
		.i_dmem_data   (i_dmem_data),
		.i_start       (i_start),
		.i_enable      (i_enable),
		.o_running     (o_running),
		.o_store_valid (o_store_valid),
		.o_store_addr  (o_store_addr),
		.o_store_data  (o_store_data)
	);

	initial
		clock = 1'b0;

	always #2 clock = ~clock;

	// store monitor, pre-edge values at the rising edge
	always @(posedge clock)
	begin
		if (reset && o_store_valid)
		begin
			if (!i_enable)
			begin
				$display("store strobe fired while i_enable was low");
				error_count++;
			end
			got_addr.push_back(o_store_addr);
			got_data.push_back(o_store_data);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding and table

	function automatic word_t make_ri4(opcode_e op, reg_idx_t d, reg_idx_t s,
		logic [3:0] imm);
		return {op, d, 1'b0, s, imm};
	endfunction

	function automatic word_t make_rrr(opcode_e op, reg_idx_t d, reg_idx_t s, reg_idx_t t);
		return make_ri4(op, d, s, {1'b0, t});
	endfunction

	function automatic word_t make_ri8(opcode_e op, reg_idx_t d, logic [7:0] imm);
		return {op, d, imm};
	endfunction

	// background pattern outside the data rows
	function automatic word_t fill_word(addr_t a);
		return {~a, a};
	endfunction

	task automatic add_word(input int p, input word_t w);
		prog_words[p][prog_len[p]] = w;
		prog_len[p]++;
	endtask

	task automatic build_table();
		for (int p = 0; p < PROG_COUNT; p++)
		begin
			prog_len[p] = 0;
			pause_at[p] = 0;
			pause_len[p] = 0;
			for (int i = 0; i < PROG_LEN; i++)
				prog_words[p][i] = NOP_WORD;
			for (int i = 0; i < DATA_COUNT; i++)
				data_words[p][i] = word_t'($random(seed));
			// r0 is the base register of every program
			add_word(p, make_rrr(OP_SUB, 3'd0, 3'd0, 3'd0));
		end
		// negative operand for the arithmetic shift
		data_words[1][3][15] = 1'b1;

		// arithmetic and logic
		add_word(0, make_ri4(OP_LOAD, 3'd1, 3'd0, 4'd0));
		add_word(0, make_ri4(OP_LOAD, 3'd2, 3'd0, 4'd1));
		add_word(0, make_rrr(OP_ADD, 3'd3, 3'd1, 3'd2));
		add_word(0, make_rrr(OP_SUB, 3'd4, 3'd1, 3'd2));
		add_word(0, make_ri4(OP_STORE, 3'd3, 3'd0, 4'd8));
		add_word(0, make_ri4(OP_STORE, 3'd4, 3'd0, 4'd9));
		add_word(0, make_rrr(OP_AND, 3'd5, 3'd1, 3'd2));
		add_word(0, make_rrr(OP_OR, 3'd6, 3'd1, 3'd2));
		add_word(0, make_rrr(OP_XOR, 3'd7, 3'd1, 3'd2));
		add_word(0, make_ri4(OP_STORE, 3'd5, 3'd0, 4'd10));
		add_word(0, make_ri4(OP_STORE, 3'd6, 3'd0, 4'd11));
		add_word(0, make_ri4(OP_STORE, 3'd7, 3'd0, 4'd12));
		add_word(0, make_ri8(OP_ADDI, 3'd1, 8'h5c));
		add_word(0, make_ri8(OP_SUBI, 3'd2, 8'ha7));
		add_word(0, make_ri8(OP_LDIH, 3'd3, 8'h3e));
		add_word(0, make_ri4(OP_STORE, 3'd1, 3'd0, 4'd13));
		add_word(0, make_ri4(OP_STORE, 3'd2, 3'd0, 4'd14));
		add_word(0, make_ri4(OP_STORE, 3'd3, 3'd0, 4'd15));
		add_word(0, make_ri4(OP_HALT, 3'd0, 3'd0, 4'd0));

		// shifts
		add_word(1, make_ri4(OP_LOAD, 3'd1, 3'd0, 4'd2));
		add_word(1, make_ri4(OP_LOAD, 3'd2, 3'd0, 4'd3));
		add_word(1, make_ri4(OP_SLL, 3'd3, 3'd1, 4'd5));
		add_word(1, make_ri4(OP_SRL, 3'd4, 3'd1, 4'd3));
		add_word(1, make_ri4(OP_SLA, 3'd5, 3'd2, 4'd1));
		add_word(1, make_ri4(OP_SRA, 3'd6, 3'd2, 4'd4));
		add_word(1, make_ri4(OP_STORE, 3'd3, 3'd0, 4'd8));
		add_word(1, make_ri4(OP_STORE, 3'd4, 3'd0, 4'd9));
		add_word(1, make_ri4(OP_STORE, 3'd5, 3'd0, 4'd10));
		add_word(1, make_ri4(OP_STORE, 3'd6, 3'd0, 4'd11));
		add_word(1, make_ri4(OP_SRA, 3'd7, 3'd1, 4'd15));
		add_word(1, make_ri4(OP_SRL, 3'd1, 3'd2, 4'd15));
		add_word(1, make_ri4(OP_STORE, 3'd7, 3'd0, 4'd12));
		add_word(1, make_ri4(OP_STORE, 3'd1, 3'd0, 4'd13));
		add_word(1, make_ri4(OP_HALT, 3'd0, 3'd0, 4'd0));

		// dependent chains and load-use pairs
		add_word(2, make_ri4(OP_LOAD, 3'd1, 3'd0, 4'd4));
		add_word(2, make_ri8(OP_ADDI, 3'd1, 8'h11));
		add_word(2, make_rrr(OP_ADD, 3'd2, 3'd1, 3'd1));
		add_word(2, make_rrr(OP_SUB, 3'd3, 3'd2, 3'd1));
		add_word(2, make_rrr(OP_XOR, 3'd4, 3'd3, 3'd2));
		add_word(2, make_ri4(OP_STORE, 3'd4, 3'd0, 4'd8));
		add_word(2, make_ri4(OP_LOAD, 3'd5, 3'd0, 4'd5));
		add_word(2, make_ri4(OP_STORE, 3'd5, 3'd0, 4'd9));
		add_word(2, make_ri4(OP_LOAD, 3'd6, 3'd0, 4'd6));
		add_word(2, NOP_WORD);
		add_word(2, make_ri4(OP_SLL, 3'd7, 3'd6, 4'd2));
		add_word(2, make_ri4(OP_LOAD, 3'd0, 3'd0, 4'd7));
		add_word(2, make_ri4(OP_STORE, 3'd7, 3'd0, 4'd10));
		add_word(2, make_ri8(OP_LDIH, 3'd7, 8'h81));
		add_word(2, make_ri4(OP_STORE, 3'd7, 3'd0, 4'd11));
		add_word(2, make_ri4(OP_HALT, 3'd0, 3'd0, 4'd0));
		pause_at[2] = 7;
		pause_len[2] = 3;

		// pause in mid-program, and a store past HALT that must not run
		add_word(3, make_ri4(OP_LOAD, 3'd1, 3'd0, 4'd0));
		add_word(3, make_ri4(OP_LOAD, 3'd2, 3'd0, 4'd1));
		add_word(3, make_rrr(OP_ADD, 3'd3, 3'd1, 3'd2));
		add_word(3, make_ri4(OP_STORE, 3'd3, 3'd0, 4'd8));
		add_word(3, make_ri8(OP_SUBI, 3'd3, 8'h01));
		add_word(3, make_rrr(OP_AND, 3'd4, 3'd3, 3'd1));
		add_word(3, make_ri4(OP_STORE, 3'd4, 3'd0, 4'd9));
		add_word(3, make_rrr(OP_OR, 3'd5, 3'd4, 3'd2));
		add_word(3, make_ri4(OP_STORE, 3'd5, 3'd0, 4'd10));
		add_word(3, make_ri4(OP_HALT, 3'd0, 3'd0, 4'd0));
		add_word(3, make_ri4(OP_STORE, 3'd5, 3'd0, 4'd12));
		// freezes while the first store sits in the memory stage
		pause_at[3] = 9;
		pause_len[3] = 6;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model, one instruction at a time

	function automatic word_t shift_right_arith(word_t v, logic [3:0] n);
		word_t r;
		r = v;
		for (int i = 0; i < n; i++)
			r = {r[WORD_WIDTH-1], r[WORD_WIDTH-1:1]};
		return r;
	endfunction

	task automatic run_model(input int p);
		int         pc;
		logic       halted;
		word_t      ir;
		opcode_e    op;
		reg_idx_t   d;
		reg_idx_t   s2;
		reg_idx_t   s3;
		logic [3:0] imm4;
		logic [7:0] imm8;
		addr_t      ea;
		exp_addr.delete();
		exp_data.delete();
		pc = 0;
		halted = 1'b0;
		while (!halted && pc < prog_len[p])
		begin
			ir = prog_words[p][pc];
			op = opcode_e'(ir[15:11]);
			d = ir[10:8];
			s2 = ir[6:4];
			s3 = ir[2:0];
			imm4 = ir[3:0];
			imm8 = ir[7:0];
			// address is base r2 plus the 4-bit offset
			ea = addr_t'(model_regs[s2] + word_t'(imm4));
			case (op)
				OP_HALT:  halted = 1'b1;
				OP_LOAD:  model_regs[d] = model_dmem[ea];
				OP_STORE:
				begin
					model_dmem[ea] = model_regs[d];
					exp_addr.push_back(ea);
					exp_data.push_back(model_regs[d]);
				end
				OP_LDIH:  model_regs[d] = model_regs[d] + {imm8, 8'h00};
				OP_ADD:   model_regs[d] = model_regs[s2] + model_regs[s3];
				OP_ADDI:  model_regs[d] = model_regs[d] + {8'h00, imm8};
				OP_SUB:   model_regs[d] = model_regs[s2] - model_regs[s3];
				OP_SUBI:  model_regs[d] = model_regs[d] - {8'h00, imm8};
				OP_AND:   model_regs[d] = model_regs[s2] & model_regs[s3];
				OP_OR:    model_regs[d] = model_regs[s2] | model_regs[s3];
				OP_XOR:   model_regs[d] = model_regs[s2] ^ model_regs[s3];
				OP_SLL,
				OP_SLA:   model_regs[d] = model_regs[s2] << imm4;
				OP_SRL:   model_regs[d] = model_regs[s2] >> imm4;
				OP_SRA:   model_regs[d] = shift_right_arith(model_regs[s2], imm4);
				default:  ;
			endcase
			pc++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus and checks

	task automatic finish_run();
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	endtask

	task automatic check_running(input logic expected);
		check_count++;
		if (o_running !== expected)
		begin
			$display("FAIL o_running: got %h, expected %h", o_running, expected);
			error_count++;
		end
	endtask

	task automatic check_idle_after_reset();
		check_running(1'b0);
		check_count++;
		if (o_store_valid !== 1'b0)
		begin
			$display("FAIL o_store_valid: got %h, expected 0", o_store_valid);
			error_count++;
		end
		// start while disabled is ignored
		i_start = 1'b1;
		i_enable = 1'b0;
		@(negedge clock);
		i_start = 1'b0;
		repeat (3)
		begin
			@(negedge clock);
			check_running(1'b0);
		end
		i_enable = 1'b1;
	endtask

	task automatic load_memories(input int p);
		for (int a = 0; a < MEM_DEPTH; a++)
		begin
			@(negedge clock);
			i_dmem_we = 1'b1;
			i_dmem_addr = addr_t'(a);
			i_dmem_data = (a < DATA_COUNT) ? data_words[p][a] : fill_word(addr_t'(a));
			model_dmem[a] = i_dmem_data;
			i_imem_we = (a < PROG_LEN);
			i_imem_addr = addr_t'(a);
			i_imem_data = (a < PROG_LEN) ? prog_words[p][a] : NOP_WORD;
		end
		@(negedge clock);
		i_dmem_we = 1'b0;
		i_imem_we = 1'b0;
	endtask

	task automatic wait_for_halt(input int p);
		int cycle;
		cycle = 0;
		while (o_running && !timed_out)
		begin
			@(negedge clock);
			cycle++;
			if (cycle == pause_at[p])
				i_enable = 1'b0;
			if (cycle == pause_at[p] + pause_len[p])
				i_enable = 1'b1;
			if (cycle > RUN_TIMEOUT)
			begin
				$display("timeout: program %0d did not halt within %0d cycles",
					p, RUN_TIMEOUT);
				error_count++;
				timed_out = 1'b1;
			end
		end
		i_enable = 1'b1;
	endtask

	task automatic check_stores(input int p);
		check_count++;
		if (got_addr.size() != exp_addr.size())
		begin
			$display("program %0d produced %0d stores, expected %0d",
				p, got_addr.size(), exp_addr.size());
			error_count++;
		end
		for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++)
		begin
			check_count += 2;
			if (got_addr[i] !== exp_addr[i])
			begin
				$display("FAIL o_store_addr: got %h, expected %h (program %0d, store %0d)",
					got_addr[i], exp_addr[i], p, i);
				error_count++;
			end
			if (got_data[i] !== exp_data[i])
			begin
				$display("FAIL o_store_data: got %h, expected %h (program %0d, store %0d)",
					got_data[i], exp_data[i], p, i);
				error_count++;
			end
		end
	endtask

	task automatic run_program(input int p);
		int stores_at_halt;
		got_addr.delete();
		got_data.delete();
		load_memories(p);
		run_model(p);
		i_start = 1'b1;
		@(negedge clock);
		i_start = 1'b0;
		check_running(1'b1);
		wait_for_halt(p);
		if (!timed_out)
		begin
			// nothing may follow the end of a program
			stores_at_halt = got_addr.size();
			repeat (4)
			begin
				@(negedge clock);
				check_running(1'b0);
			end
			check_count++;
			if (got_addr.size() != stores_at_halt)
			begin
				$display("a store strobe followed the end of program %0d", p);
				error_count++;
			end
			check_stores(p);
		end
	endtask

	initial
	begin
		seed = 32'hd42b_b2eb;
		error_count = 0;
		check_count = 0;
		timed_out = 1'b0;
		reset = 1'b0;
		i_imem_we = 1'b0;
		i_imem_addr = '0;
		i_imem_data = '0;
		i_dmem_we = 1'b0;
		i_dmem_addr = '0;
		i_dmem_data = '0;
		i_start = 1'b0;
		i_enable = 1'b0;
		for (int i = 0; i < REG_COUNT; i++)
			model_regs[i] = '0;
		build_table();
		repeat (10) @(negedge clock);
		reset = 1'b1;
		@(negedge clock);
		check_idle_after_reset();
		for (int p = 0; p < PROG_COUNT && !timed_out; p++)
			run_program(p);
		finish_run();
	end

endmodule

`default_nettype wire

/* all.f */
logic/pcpu_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/pcpu_top.sv
verification/pcpu_tb.sv

/* Bender.yml */
package:
  name: pcpu

sources:
  - logic/pcpu_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/pcpu_top.sv
  - target: test
    files:
      - verification/pcpu_tb.sv
